// ==== verilog/isaPkg.sv ====
//==================================================
// ISA definitions of the 32-bit teaching CPU
// Word, register index, immediate and opcode types
//==================================================
package isaPkg;

    // Field widths
    localparam int wordW   = 32;
    localparam int regIdxW = 4;
    localparam int immW    = 16;
    localparam int opcodeW = 7;

    // Field positions in the instruction word
    localparam int opcodeLsb = 25;
    localparam int rdLsb     = 21;
    localparam int rsLsb     = 17;
    localparam int rtLsb     = 13;

    typedef logic [wordW-1:0]        wordT;
    typedef logic [regIdxW-1:0]      regIdxT;
    typedef logic signed [immW-1:0]  immT;

    // Opcode in bits 31:25
    typedef enum logic [opcodeW-1:0] {
        opAdd  = 7'b0000001,
        opSub  = 7'b0000010,
        opAnd  = 7'b0000011,
        opOr   = 7'b0000100,
        opXor  = 7'b0000101,
        opAddi = 7'b0001000,
        opBeq  = 7'b1000000,
        opB    = 7'b1100000,
        opNop  = 7'b1100100
    } opcodeT;

    // Immediate widened to a full word
    function automatic wordT signExtImm(immT imm);
        return {{(wordW - immW){imm[immW-1]}}, imm};
    endfunction

endpackage

// ==== verilog/uarchPkg.sv ====
//==================================================
// Internal pipeline definitions
// ALU operation passed from decode to execute
//==================================================
package uarchPkg;

    // ALU operation selected by decode
    // aluNone marks words with no ALU result (BEQ)
    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluSub  = 3'd1,
        aluAnd  = 3'd2,
        aluOr   = 3'd3,
        aluXor  = 3'd4,
        aluNone = 3'd7
    } aluOpT;

endpackage

// ==== verilog/iFetch.sv ====
//==================================================
// Instruction fetch with PC, B redirect and
// BEQ override, drops B and NOP words
//==================================================
`timescale 1ns/1ps

module iFetch
    import isaPkg::*;
#(
    parameter wordT resetVector = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic hold,
    input  wordT fetchedInstruction,
    input  logic exeOverride,
    input  wordT exeTarget,
    output wordT programCounter,
    output logic fdValid,
    output wordT fdInstr,
    output wordT fdPc
);

    typedef enum logic {
        sIdle,
        sFilter
    } fetchStateT;

    fetchStateT state;
    opcodeT     fetchedOp;
    immT        branchImm;
    wordT       pcNext;
    logic       keepWord;

    assign fetchedOp = opcodeT'(fetchedInstruction[opcodeLsb +: opcodeW]);
    assign branchImm = immT'(fetchedInstruction[immW-1:0]);

    //==================================================
    // Next PC and filter
    //==================================================
    always_comb begin
        pcNext   = programCounter + 32'd4;
        keepWord = 1'b0;
        case (state)
            sIdle: begin
                // First real fetch address
                pcNext = resetVector;
            end
            sFilter: begin
                // Override from execute wins over a B in the same cycle
                if (exeOverride) begin
                    pcNext = exeTarget;
                end else if (fetchedOp == opB) begin
                    pcNext = programCounter + signExtImm(branchImm);
                end else begin
                    keepWord = (fetchedOp != opNop);
                end
            end
            default: begin
                pcNext = resetVector;
            end
        endcase
    end

    //==================================================
    // State, PC and fetch/decode register
    //==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= sIdle;
            programCounter <= '0;
            fdValid        <= 1'b0;
        end else if (!hold) begin
            state          <= sFilter;
            programCounter <= pcNext;
            fdValid        <= keepWord;
        end
    end

    // Payload only moves with a kept word
    always_ff @(posedge clk) begin
        if (!hold && keepWord) begin
            fdInstr <= fetchedInstruction;
            fdPc    <= programCounter;
        end
    end

endmodule

// ==== verilog/iDecode.sv ====
//==================================================
// Instruction decode and register operand read
//==================================================
`timescale 1ns/1ps

module iDecode
    import isaPkg::*;
    import uarchPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   hold,
    input  logic   fdValid,
    input  wordT   fdInstr,
    input  wordT   fdPc,
    input  logic   exeOverride,
    input  logic   wbWe,
    input  regIdxT wbRd,
    input  wordT   wbData,
    input  wordT   rfRdA,
    input  wordT   rfRdB,
    output regIdxT rfAddrA,
    output regIdxT rfAddrB,
    output logic   deValid,
    output wordT   dePc,
    output aluOpT  deAluOp,
    output logic   deIsBeq,
    output logic   deUseImm,
    output regIdxT deRd,
    output logic   deWe,
    output wordT   deOpA,
    output wordT   deOpB,
    output wordT   deImm,
    output regIdxT deRs,
    output regIdxT deRt
);

    opcodeT opcode;
    regIdxT rd;
    regIdxT rs;
    regIdxT rt;
    immT    imm;
    aluOpT  aluOp;
    logic   useImm;
    logic   isBeq;
    logic   writes;
    wordT   opA;
    wordT   opB;

    assign opcode = opcodeT'(fdInstr[opcodeLsb +: opcodeW]);
    assign rd     = fdInstr[rdLsb +: regIdxW];
    assign rs     = fdInstr[rsLsb +: regIdxW];
    assign rt     = fdInstr[rtLsb +: regIdxW];
    assign imm    = immT'(fdInstr[immW-1:0]);

    //==================================================
    // Opcode to ALU operation and flags
    //==================================================
    always_comb begin
        aluOp  = aluNone;
        useImm = 1'b0;
        isBeq  = 1'b0;
        case (opcode)
            opAdd:  aluOp = aluAdd;
            opSub:  aluOp = aluSub;
            opAnd:  aluOp = aluAnd;
            opOr:   aluOp = aluOr;
            opXor:  aluOp = aluXor;
            opAddi: begin
                aluOp  = aluAdd;
                useImm = 1'b1;
            end
            opBeq:  isBeq = 1'b1;
            default: aluOp = aluNone;
        endcase
        writes = (aluOp != aluNone);
    end

    // BEQ compares rd with rs
    assign rfAddrA = isBeq ? rd : rs;
    assign rfAddrB = isBeq ? rs : rt;

    // Bypass a write landing in the same cycle
    assign opA = (wbWe && wbRd == rfAddrA) ? wbData : rfRdA;
    assign opB = (wbWe && wbRd == rfAddrB) ? wbData : rfRdB;

    //==================================================
    // Decode/execute register
    //==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            deValid <= 1'b0;
            deWe    <= 1'b0;
            deIsBeq <= 1'b0;
        end else if (!hold) begin
            // Younger word squashed by a taken BEQ
            deValid <= fdValid && !exeOverride;
            deWe    <= writes;
            deIsBeq <= isBeq;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            dePc     <= fdPc;
            deAluOp  <= aluOp;
            deUseImm <= useImm;
            deRd     <= rd;
            deOpA    <= opA;
            deOpB    <= opB;
            deImm    <= signExtImm(imm);
            // Source indices of the two operands as read
            deRs     <= rfAddrA;
            deRt     <= rfAddrB;
        end
    end

endmodule

// ==== verilog/iExecute.sv ====
//==================================================
// Execute stage with forwarding, ALU and BEQ
//==================================================
`timescale 1ns/1ps

module iExecute
    import isaPkg::*;
    import uarchPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   hold,
    input  logic   deValid,
    input  wordT   dePc,
    input  aluOpT  deAluOp,
    input  logic   deIsBeq,
    input  logic   deUseImm,
    input  regIdxT deRd,
    input  logic   deWe,
    input  wordT   deOpA,
    input  wordT   deOpB,
    input  wordT   deImm,
    input  regIdxT deRs,
    input  regIdxT deRt,
    input  logic   wbWe,
    input  regIdxT wbRd,
    input  wordT   wbData,
    output logic   exeOverride,
    output wordT   exeTarget,
    output logic   erValid,
    output wordT   erPc,
    output logic   erWe,
    output regIdxT erRd,
    output wordT   erData
);

    wordT opA;
    wordT opB;
    wordT aluB;
    wordT aluResult;

    // Forward from the result stage write
    assign opA  = (wbWe && wbRd == deRs) ? wbData : deOpA;
    assign opB  = (wbWe && wbRd == deRt) ? wbData : deOpB;
    assign aluB = deUseImm ? deImm : opB;

    always_comb begin
        case (deAluOp)
            aluAdd:  aluResult = opA + aluB;
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluXor:  aluResult = opA ^ aluB;
            default: aluResult = '0;
        endcase
    end

    //==================================================
    // Conditional branch resolution
    //==================================================
    assign exeOverride = deValid && deIsBeq && (opA == opB);
    // Full target, fetch has no record of the branch PC
    assign exeTarget   = dePc + deImm;

    always_ff @(posedge clk) begin
        if (rst) begin
            erValid <= 1'b0;
            erWe    <= 1'b0;
        end else if (!hold) begin
            erValid <= deValid;
            erWe    <= deWe && !deIsBeq;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            erPc   <= dePc;
            erRd   <= deRd;
            erData <= aluResult;
        end
    end

endmodule

// ==== verilog/iResult.sv ====
//==================================================
// Result stage with register file and retire port
//==================================================
`timescale 1ns/1ps

module iResult
    import isaPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   hold,
    input  logic   erValid,
    input  wordT   erPc,
    input  logic   erWe,
    input  regIdxT erRd,
    input  wordT   erData,
    input  regIdxT rfAddrA,
    input  regIdxT rfAddrB,
    output wordT   rfRdA,
    output wordT   rfRdB,
    output logic   wbWe,
    output regIdxT wbRd,
    output wordT   wbData,
    output logic   retireValid,
    output wordT   retirePc,
    output logic   retireWe,
    output regIdxT retireRd,
    output wordT   retireData
);

    wordT regFile [0:(1 << regIdxW) - 1];
    logic retireValidReg;

    // Write port doubles as the forwarding source
    assign wbWe   = erValid && erWe;
    assign wbRd   = erRd;
    assign wbData = erData;

    assign rfRdA = regFile[rfAddrA];
    assign rfRdB = regFile[rfAddrB];

    //==================================================
    // Writeback and retire register
    //==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << regIdxW); i++) begin
                regFile[i] <= '0;
            end
            retireValidReg <= 1'b0;
        end else if (!hold) begin
            if (wbWe) begin
                regFile[erRd] <= erData;
            end
            retireValidReg <= erValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            retirePc   <= erPc;
            retireWe   <= erWe;
            retireRd   <= erRd;
            retireData <= erData;
        end
    end

    // A pending retire reappears once hold drops
    assign retireValid = retireValidReg && !hold;

endmodule

// ==== verilog/cpuPipeline.sv ====
//==================================================
// Four stage integer pipeline top level
//==================================================
`timescale 1ns/1ps

module cpuPipeline
    import isaPkg::*;
    import uarchPkg::*;
#(
    parameter wordT resetVector = '0
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   hold,
    input  wordT   fetchedInstruction,
    output wordT   programCounter,
    output logic   retireValid,
    output wordT   retirePc,
    output logic   retireWe,
    output regIdxT retireRd,
    output wordT   retireData
);

    // Fetch to decode
    logic   fdValid;
    wordT   fdInstr;
    wordT   fdPc;

    // Decode to execute
    logic   deValid;
    wordT   dePc;
    aluOpT  deAluOp;
    logic   deIsBeq;
    logic   deUseImm;
    regIdxT deRd;
    logic   deWe;
    wordT   deOpA;
    wordT   deOpB;
    wordT   deImm;
    regIdxT deRs;
    regIdxT deRt;

    // Execute to result, branch feedback
    logic   erValid;
    wordT   erPc;
    logic   erWe;
    regIdxT erRd;
    wordT   erData;
    logic   exeOverride;
    wordT   exeTarget;

    // Register file and write port
    regIdxT rfAddrA;
    regIdxT rfAddrB;
    wordT   rfRdA;
    wordT   rfRdB;
    logic   wbWe;
    regIdxT wbRd;
    wordT   wbData;

    iFetch #(
        .resetVector(resetVector)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .hold(hold),
        .fetchedInstruction(fetchedInstruction),
        .exeOverride(exeOverride),
        .exeTarget(exeTarget),
        .programCounter(programCounter),
        .fdValid(fdValid),
        .fdInstr(fdInstr),
        .fdPc(fdPc)
    );

    iDecode u_decode (
        .clk(clk),
        .rst(rst),
        .hold(hold),
        .fdValid(fdValid),
        .fdInstr(fdInstr),
        .fdPc(fdPc),
        .exeOverride(exeOverride),
        .wbWe(wbWe),
        .wbRd(wbRd),
        .wbData(wbData),
        .rfRdA(rfRdA),
        .rfRdB(rfRdB),
        .rfAddrA(rfAddrA),
        .rfAddrB(rfAddrB),
        .deValid(deValid),
        .dePc(dePc),
        .deAluOp(deAluOp),
        .deIsBeq(deIsBeq),
        .deUseImm(deUseImm),
        .deRd(deRd),
        .deWe(deWe),
        .deOpA(deOpA),
        .deOpB(deOpB),
        .deImm(deImm),
        .deRs(deRs),
        .deRt(deRt)
    );

    iExecute u_execute (
        .clk(clk),
        .rst(rst),
        .hold(hold),
        .deValid(deValid),
        .dePc(dePc),
        .deAluOp(deAluOp),
        .deIsBeq(deIsBeq),
        .deUseImm(deUseImm),
        .deRd(deRd),
        .deWe(deWe),
        .deOpA(deOpA),
        .deOpB(deOpB),
        .deImm(deImm),
        .deRs(deRs),
        .deRt(deRt),
        .wbWe(wbWe),
        .wbRd(wbRd),
        .wbData(wbData),
        .exeOverride(exeOverride),
        .exeTarget(exeTarget),
        .erValid(erValid),
        .erPc(erPc),
        .erWe(erWe),
        .erRd(erRd),
        .erData(erData)
    );

    iResult u_result (
        .clk(clk),
        .rst(rst),
        .hold(hold),
        .erValid(erValid),
        .erPc(erPc),
        .erWe(erWe),
        .erRd(erRd),
        .erData(erData),
        .rfAddrA(rfAddrA),
        .rfAddrB(rfAddrB),
        .rfRdA(rfRdA),
        .rfRdB(rfRdB),
        .wbWe(wbWe),
        .wbRd(wbRd),
        .wbData(wbData),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireWe(retireWe),
        .retireRd(retireRd),
        .retireData(retireData)
    );

endmodule

// ==== tests/fetchSva.sv ====
//==================================================
// Fetch assertions on hold, alignment and redirect
//==================================================
`timescale 1ns/1ps

module fetchSva
    import isaPkg::*;
(
    input logic clk,
    input logic rst,
    input logic hold,
    input logic exeOverride,
    input wordT exeTarget,
    input wordT programCounter
);

    // Count of failed checks
    int failCount;

    initial failCount = 0;

    // PC frozen while the pipeline is held
    pcHoldStable: assert property (@(posedge clk) disable iff (rst)
        hold |=> $stable(programCounter))
    else begin
        failCount++;
        $error("programCounter changed while hold was high");
    end

    // Word fetches only
    pcAligned: assert property (@(posedge clk) disable iff (rst)
        programCounter[1:0] == 2'b00)
    else begin
        failCount++;
        $error("programCounter is not word aligned");
    end

    // Taken BEQ redirects fetch to its target
    pcOverride: assert property (@(posedge clk) disable iff (rst)
        (exeOverride && !hold) |=> (programCounter == $past(exeTarget)))
    else begin
        failCount++;
        $error("programCounter missed the BEQ target");
    end

endmodule

bind iFetch fetchSva u_fetchSva (
    .clk(clk),
    .rst(rst),
    .hold(hold),
    .exeOverride(exeOverride),
    .exeTarget(exeTarget),
    .programCounter(programCounter)
);

// ==== tests/cpuPipelineTb.sv ====
//==================================================
// Testbench for the four stage pipeline with a random
// circular program checked against an ISA model
//==================================================
`timescale 1ns/1ps

module cpuPipelineTb
    import isaPkg::*;
();

    localparam wordT startPc    = 32'h0000_0080;
    localparam int   retireGoal = 400;
    localparam int   idleLimit  = 40;
    localparam int   cycleLimit = 20000;

    logic   clk;
    logic   rst;
    logic   hold;
    wordT   fetchedInstruction;
    wordT   programCounter;
    logic   retireValid;
    wordT   retirePc;
    logic   retireWe;
    regIdxT retireRd;
    wordT   retireData;

    wordT        progMem [0:63];
    wordT        modelRegs [0:15];
    wordT        modelPc;
    logic [31:0] rngState;

    cpuPipeline #(
        .resetVector(startPc)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .hold(hold),
        .fetchedInstruction(fetchedInstruction),
        .programCounter(programCounter),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireWe(retireWe),
        .retireRd(retireRd),
        .retireData(retireData)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Circular instruction memory, word index modulo 64
    always @(negedge clk) begin
        fetchedInstruction = progMem[programCounter[7:2]];
    end

    //==================================================
    // Random numbers and instruction encoding
    //==================================================
    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic wordT encodeReg(opcodeT op, regIdxT rd, regIdxT rs, regIdxT rt);
        return {op, rd, rs, rt, 13'd0};
    endfunction

    function automatic wordT encodeImm(opcodeT op, regIdxT rd, regIdxT rs, logic [15:0] imm);
        return {op, rd, rs, 1'b0, imm};
    endfunction

    function automatic wordT signExtend16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // Byte offset of a nonzero word count, odd counts for B
    function automatic logic [15:0] branchOffset(logic [31:0] v, logic oddWords);
        int words;
        if (oddWords) begin
            words = 2 * int'(v[18:16]) + 1;
        end else begin
            words = int'(v[18:16]) + 1;
        end
        if (v[20]) begin
            words = -words;
        end
        return 16'(words * 4);
    endfunction

    task automatic buildProgram();
        logic [31:0] r;
        logic [31:0] v;
        int          sel;
        opcodeT      op;
        regIdxT      rd;
        regIdxT      rs;
        regIdxT      rt;
        for (int i = 0; i < 64; i++) begin
            r   = nextRandom();
            v   = nextRandom();
            sel = int'(r[31:28]);
            // Small register pool for frequent dependences
            rd  = {1'b0, r[2:0]};
            rs  = {1'b0, r[6:4]};
            rt  = {1'b0, r[10:8]};
            if (i % 2 == 0 && sel < 2) begin
                progMem[i] = encodeImm(opB, rd, rs, branchOffset(v, 1'b1));
            end else if (i % 2 == 0 && sel == 2) begin
                progMem[i] = encodeReg(opNop, 4'd0, 4'd0, 4'd0);
            end else if (sel < 5) begin
                progMem[i] = encodeImm(opBeq, rd, rs, branchOffset(v, 1'b0));
            end else if (sel < 8) begin
                progMem[i] = encodeImm(opAddi, rd, rs, v[15:0]);
            end else begin
                case (int'(r[14:12]) % 5)
                    0: op = opAdd;
                    1: op = opSub;
                    2: op = opAnd;
                    3: op = opOr;
                    default: op = opXor;
                endcase
                progMem[i] = encodeReg(op, rd, rs, rt);
            end
        end
    endtask

    //==================================================
    // Checks
    //==================================================
    task automatic stopOnError(string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkWord(string name, wordT got, wordT exp);
        if (got !== exp) begin
            stopOnError($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkReg(string name, regIdxT got, regIdxT exp);
        if (got !== exp) begin
            stopOnError($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            stopOnError($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Sequential interpreter, runs up to the next retiring instruction
    task automatic predictRetire(output wordT pc, output logic we, output regIdxT rd,
                                 output wordT data);
        wordT   instr;
        opcodeT op;
        regIdxT fRs;
        regIdxT fRt;
        wordT   imm;
        logic   found;
        int     steps;
        found = 1'b0;
        steps = 0;
        while (!found) begin
            if (steps == 64) begin
                stopOnError("model stepped 64 words without a retiring instruction");
            end
            steps++;
            instr = progMem[modelPc[7:2]];
            op    = opcodeT'(instr[31:25]);
            rd    = instr[24:21];
            fRs   = instr[20:17];
            fRt   = instr[16:13];
            imm   = signExtend16(instr[15:0]);
            pc    = modelPc;
            found = 1'b1;
            we    = 1'b1;
            data  = '0;
            case (op)
                opAdd:  data = modelRegs[fRs] + modelRegs[fRt];
                opSub:  data = modelRegs[fRs] - modelRegs[fRt];
                opAnd:  data = modelRegs[fRs] & modelRegs[fRt];
                opOr:   data = modelRegs[fRs] | modelRegs[fRt];
                opXor:  data = modelRegs[fRs] ^ modelRegs[fRt];
                opAddi: data = modelRegs[fRs] + imm;
                opBeq:  we = 1'b0;
                opB:    found = 1'b0;
                opNop:  found = 1'b0;
                default: stopOnError("model met an unknown opcode");
            endcase
            if (op == opB || (op == opBeq && modelRegs[rd] == modelRegs[fRs])) begin
                modelPc = modelPc + imm;
            end else begin
                modelPc = modelPc + 32'd4;
            end
            if (found && we) begin
                modelRegs[rd] = data;
            end
        end
    endtask

    //==================================================
    // Stimulus and retire checking
    //==================================================
    initial begin
        wordT        expPc;
        logic        expWe;
        regIdxT      expRd;
        wordT        expData;
        int          retired;
        int          idleCycles;
        int          cycles;
        int          holdLeft;
        logic [31:0] r;

        rst                = 1'b1;
        hold               = 1'b0;
        fetchedInstruction = '0;
        rngState           = 32'h3610_d2e2;
        retired            = 0;
        idleCycles         = 0;
        cycles             = 0;
        holdLeft           = 0;
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
        modelPc = startPc;
        buildProgram();

        repeat (4) begin
            @(posedge clk);
            #1;
            checkBit("retireValid", retireValid, 1'b0);
        end
        @(negedge clk);
        rst = 1'b0;

        while (retired < retireGoal) begin
            // Hold runs of one to four cycles
            if (holdLeft > 0) begin
                hold = 1'b1;
                holdLeft--;
            end else begin
                r        = nextRandom();
                hold     = (r[3:0] == 4'd0);
                holdLeft = hold ? int'(r[5:4]) : 0;
            end
            #1;
            if (u_dut.u_fetch.u_fetchSva.failCount != 0) begin
                stopOnError("a fetch assertion failed");
            end
            if (hold) begin
                checkBit("retireValid", retireValid, 1'b0);
            end else if (retireValid) begin
                predictRetire(expPc, expWe, expRd, expData);
                checkWord("retirePc", retirePc, expPc);
                checkBit("retireWe", retireWe, expWe);
                if (expWe) begin
                    checkReg("retireRd", retireRd, expRd);
                    checkWord("retireData", retireData, expData);
                end
                retired++;
                idleCycles = 0;
            end else begin
                idleCycles++;
                if (idleCycles > idleLimit) begin
                    stopOnError("no retirement within 40 cycles without hold");
                end
            end
            cycles++;
            if (cycles > cycleLimit) begin
                stopOnError("run did not reach 400 retirements in time");
            end
            @(negedge clk);
        end

        if (u_dut.u_fetch.u_fetchSva.failCount == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stopOnError("a fetch assertion failed");
        end
    end

endmodule

// ==== vlog.f ====
verilog/isaPkg.sv
verilog/uarchPkg.sv
verilog/iFetch.sv
verilog/iDecode.sv
verilog/iExecute.sv
verilog/iResult.sv
verilog/cpuPipeline.sv
tests/fetchSva.sv
tests/cpuPipelineTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpuPipelineTb -f vlog.f -o simPipeline

./obj_dir/simPipeline +verilator+error+limit+100 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
